//--- vecu_pkg.sv
package vecu_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    // bank depth, also the longest legal vector
    localparam int MAX_LEN = 1024;

    // one unsigned element
    typedef logic [7:0]  elem_t;
    // element index inside a bank
    typedef logic [9:0]  addr_t;
    // vector length, 1 to MAX_LEN
    typedef logic [10:0] len_t;
    // raw command byte from the host
    typedef logic [7:0]  cmd_t;
    // output word, holds a 1024-element dot product
    typedef logic [31:0] result_t;

    //////////////////////////////////////////////////////////////////////
    // command byte layout
    //////////////////////////////////////////////////////////////////////

    localparam int CMD_WRITE = 0;
    localparam int CMD_READ  = 1;
    localparam int CMD_SUM   = 2;
    localparam int CMD_AVG   = 3;
    localparam int CMD_EUC   = 4;
    localparam int CMD_MAN   = 5;
    localparam int CMD_DOT   = 6;
    // bank select for write and read, 0 is A
    localparam int CMD_BANK  = 7;

    // operation tag carried by every issued element
    typedef enum logic [2:0] {
        OP_READ_A,
        OP_READ_B,
        OP_SUM,
        OP_AVG,
        OP_EUC,
        OP_MAN,
        OP_DOT
    } op_t;

endpackage

//--- vecu_regs.sv
`timescale 1ns/1ps

module vecu_regs
    import vecu_pkg::*;
#(
    parameter len_t DEFAULT_LEN = len_t'(16)
) (
    input  logic clk,
    input  logic reset,
    input  logic cfg_valid,
    input  len_t cfg_len,
    input  logic busy,
    output len_t vec_len
);

    // host value forced into 1..MAX_LEN
    len_t len_clamped;

    //////////////////////////////////////////////////////////////////////
    // clamp
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (cfg_len == '0) begin
            // zero length makes no sense, keep one element
            len_clamped = len_t'(1);
        end else if (cfg_len > len_t'(MAX_LEN)) begin
            len_clamped = len_t'(MAX_LEN);
        end else begin
            len_clamped = cfg_len;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // length register
    //////////////////////////////////////////////////////////////////////

    // only updated while idle, so the sequencer sees a stable length
    // for the whole command
    always_ff @(posedge clk) begin
        if (reset) begin
            vec_len <= DEFAULT_LEN;
        end else if (cfg_valid && !busy) begin
            vec_len <= len_clamped;
        end
    end

endmodule

//--- vecu_ctrl.sv
`timescale 1ns/1ps

module vecu_ctrl
    import vecu_pkg::*;
#(
    parameter int CREDITS = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  cmd_valid,
    input  cmd_t  cmd,
    input  logic  in_valid,
    input  elem_t in_data,
    input  len_t  vec_len,
    input  logic  out_credit,
    input  logic  out_valid,
    input  logic  out_last,
    output logic  busy,
    output logic  issue_valid,
    output addr_t issue_addr,
    output op_t   issue_op,
    output logic  issue_last,
    output logic  wr_en,
    output logic  wr_bank,
    output addr_t wr_addr,
    output elem_t wr_data
);

    // counter wide enough to hold CREDITS itself
    localparam int CW = $clog2(CREDITS + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE,
        S_ISSUE,
        S_DRAIN
    } state_t;

    state_t        state;
    op_t           op_q;
    logic          bank_q;
    addr_t         addr_q;
    logic [CW-1:0] credit_q;

    logic cmd_take;
    logic dec_write;
    op_t  dec_op;
    len_t last_idx;
    logic at_last;
    logic emits;
    logic spend;

    //////////////////////////////////////////////////////////////////////
    // command decode
    //////////////////////////////////////////////////////////////////////

    // lowest set bit wins
    always_comb begin
        dec_write = 1'b0;
        dec_op    = OP_READ_A;
        if (cmd[CMD_WRITE]) begin
            dec_write = 1'b1;
        end else if (cmd[CMD_READ]) begin
            dec_op = cmd[CMD_BANK] ? OP_READ_B : OP_READ_A;
        end else if (cmd[CMD_SUM]) begin
            dec_op = OP_SUM;
        end else if (cmd[CMD_AVG]) begin
            dec_op = OP_AVG;
        end else if (cmd[CMD_EUC]) begin
            dec_op = OP_EUC;
        end else if (cmd[CMD_MAN]) begin
            dec_op = OP_MAN;
        end else if (cmd[CMD_DOT]) begin
            dec_op = OP_DOT;
        end
    end

    // bytes without any op bit are dropped here
    assign cmd_take = (state == S_IDLE) && cmd_valid && (|cmd[CMD_DOT:CMD_WRITE]);

    // op and bank held for the whole command
    always_ff @(posedge clk) begin
        if (cmd_take) begin
            op_q   <= dec_op;
            bank_q <= cmd[CMD_BANK];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////////////////////////

    assign last_idx = vec_len - len_t'(1);
    assign at_last  = (len_t'(addr_q) == last_idx);

    // one address counter serves both write and issue
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_IDLE;
            addr_q <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_take) begin
                        addr_q <= '0;
                        state  <= dec_write ? S_WRITE : S_ISSUE;
                    end
                end
                S_WRITE: begin
                    // one element per in_valid, no back-pressure
                    if (in_valid) begin
                        if (at_last) begin
                            addr_q <= '0;
                            state  <= S_IDLE;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                end
                S_ISSUE: begin
                    if (issue_valid) begin
                        if (at_last) begin
                            addr_q <= '0;
                            state  <= S_DRAIN;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                end
                S_DRAIN: begin
                    // last word leaves the core, busy drops next cycle
                    if (out_valid && out_last) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // credits
    //////////////////////////////////////////////////////////////////////

    // element-wise ops emit every element, reductions only the last
    assign emits = (op_q inside {OP_READ_A, OP_READ_B, OP_SUM, OP_AVG}) || at_last;
    assign spend = issue_valid && emits;

    // spend and return may land in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_q <= CW'(CREDITS);
        end else begin
            credit_q <= credit_q + CW'(out_credit) - CW'(spend);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    assign busy        = (state != S_IDLE);
    // stall issue while the receiver has no room
    assign issue_valid = (state == S_ISSUE) && (credit_q != '0);
    assign issue_addr  = addr_q;
    assign issue_op    = op_q;
    assign issue_last  = at_last;

    assign wr_en   = (state == S_WRITE) && in_valid;
    assign wr_bank = bank_q;
    assign wr_addr = addr_q;
    assign wr_data = in_data;

endmodule

//--- vecu_bank.sv
`timescale 1ns/1ps

module vecu_bank
    import vecu_pkg::*;
(
    input  logic  clk,
    input  logic  wr_en,
    input  logic  wr_bank,
    input  addr_t wr_addr,
    input  elem_t wr_data,
    input  logic  issue_valid,
    input  addr_t issue_addr,
    input  op_t   issue_op,
    input  logic  issue_last,
    input  logic  reset,
    output logic  rd_valid,
    output elem_t rd_a,
    output elem_t rd_b,
    output op_t   rd_op,
    output logic  rd_last
);

    // vector A and vector B
    elem_t mem_a [MAX_LEN];
    elem_t mem_b [MAX_LEN];

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////

    // bank select picks one memory per write
    always_ff @(posedge clk) begin
        if (wr_en && !wr_bank) begin
            mem_a[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && wr_bank) begin
            mem_b[wr_addr] <= wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered read
    //////////////////////////////////////////////////////////////////////

    // both banks read at the same index, tags ride along
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            rd_a    <= mem_a[issue_addr];
            rd_b    <= mem_b[issue_addr];
            rd_op   <= issue_op;
            rd_last <= issue_last;
        end
    end

    // valid lags issue_valid by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= issue_valid;
        end
    end

endmodule

//--- vecu_core.sv
`timescale 1ns/1ps

module vecu_core
    import vecu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    rd_valid,
    input  elem_t   rd_a,
    input  elem_t   rd_b,
    input  op_t     rd_op,
    input  logic    rd_last,
    output logic    out_valid,
    output result_t out_data,
    output logic    out_last
);

    logic [8:0] pair_sum;
    elem_t      abs_diff;
    result_t    elem_res;
    result_t    term;
    result_t    acc;
    logic       reduce;
    logic       emit;

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // nine bits keep the carry of a + b
        pair_sum = {1'b0, rd_a} + {1'b0, rd_b};
        abs_diff = (rd_a >= rd_b) ? (rd_a - rd_b) : (rd_b - rd_a);
        reduce   = (rd_op == OP_EUC) || (rd_op == OP_MAN) || (rd_op == OP_DOT);

        // one word per element
        case (rd_op)
            OP_READ_A: elem_res = result_t'(rd_a);
            OP_READ_B: elem_res = result_t'(rd_b);
            OP_SUM:    elem_res = result_t'(pair_sum);
            // floor of the half-sum
            OP_AVG:    elem_res = result_t'(pair_sum[8:1]);
            default:   elem_res = '0;
        endcase

        // contribution of this element to a reduction
        case (rd_op)
            OP_EUC:  term = result_t'(abs_diff) * result_t'(abs_diff);
            OP_MAN:  term = result_t'(abs_diff);
            OP_DOT:  term = result_t'(rd_a) * result_t'(rd_b);
            default: term = '0;
        endcase
    end

    // reductions speak only on their last element
    assign emit = rd_valid && (!reduce || rd_last);

    //////////////////////////////////////////////////////////////////////
    // accumulator and output stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            acc       <= '0;
        end else begin
            out_valid <= emit;
            out_last  <= emit && (reduce || rd_last);
            if (rd_valid && reduce) begin
                if (rd_last) begin
                    // fresh start for the next reduction
                    acc <= '0;
                end else begin
                    acc <= acc + term;
                end
            end
        end
    end

    // last element folded in on the way out
    always_ff @(posedge clk) begin
        if (emit) begin
            out_data <= reduce ? (acc + term) : elem_res;
        end
    end

endmodule

//--- vecu_top.sv
`timescale 1ns/1ps

module vecu_top
    import vecu_pkg::*;
#(
    parameter int   CREDITS     = 4,
    parameter len_t DEFAULT_LEN = len_t'(16)
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    cfg_valid,
    input  len_t    cfg_len,
    input  logic    cmd_valid,
    input  cmd_t    cmd,
    input  logic    in_valid,
    input  elem_t   in_data,
    input  logic    out_credit,
    output logic    busy,
    output logic    out_valid,
    output result_t out_data,
    output logic    out_last
);

    len_t  vec_len;

    // sequencer to banks
    logic  issue_valid;
    addr_t issue_addr;
    op_t   issue_op;
    logic  issue_last;
    logic  wr_en;
    logic  wr_bank;
    addr_t wr_addr;
    elem_t wr_data;

    // banks to core
    logic  rd_valid;
    elem_t rd_a;
    elem_t rd_b;
    op_t   rd_op;
    logic  rd_last;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    vecu_regs #(
        .DEFAULT_LEN (DEFAULT_LEN)
    ) i_regs (
        .clk       (clk),
        .reset     (reset),
        .cfg_valid (cfg_valid),
        .cfg_len   (cfg_len),
        .busy      (busy),
        .vec_len   (vec_len)
    );

    // out_valid and out_last double as the drain signal
    vecu_ctrl #(
        .CREDITS (CREDITS)
    ) i_ctrl (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .vec_len     (vec_len),
        .out_credit  (out_credit),
        .out_valid   (out_valid),
        .out_last    (out_last),
        .busy        (busy),
        .issue_valid (issue_valid),
        .issue_addr  (issue_addr),
        .issue_op    (issue_op),
        .issue_last  (issue_last),
        .wr_en       (wr_en),
        .wr_bank     (wr_bank),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    //////////////////////////////////////////////////////////////////////
    // datapath, two stages from issue to output
    //////////////////////////////////////////////////////////////////////

    vecu_bank i_bank (
        .clk         (clk),
        .wr_en       (wr_en),
        .wr_bank     (wr_bank),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .issue_valid (issue_valid),
        .issue_addr  (issue_addr),
        .issue_op    (issue_op),
        .issue_last  (issue_last),
        .reset       (reset),
        .rd_valid    (rd_valid),
        .rd_a        (rd_a),
        .rd_b        (rd_b),
        .rd_op       (rd_op),
        .rd_last     (rd_last)
    );

    vecu_core i_core (
        .clk       (clk),
        .reset     (reset),
        .rd_valid  (rd_valid),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .rd_op     (rd_op),
        .rd_last   (rd_last),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last)
    );

endmodule

//--- vecu_tb.sv
`timescale 1ns/1ps

module vecu_tb
    import vecu_pkg::*;
();

    localparam int CREDITS     = 4;
    localparam int DEF_LEN     = 16;
    // cycles a credit is held back in the slow receiver mode
    localparam int HOLD_CYCLES = 24;
    localparam int NUM_STEPS   = 19;

    // extra host activity while a command runs
    localparam logic [1:0] POKE_NONE = 2'd0;
    localparam logic [1:0] POKE_CFG  = 2'd1;
    localparam logic [1:0] POKE_CMD  = 2'd2;

    // len of 0 keeps the current length
    typedef struct packed {
        cmd_t       cmd;
        len_t       len;
        logic       withhold;
        logic [1:0] poke;
    } step_t;

    logic    clk        = 1'b0;
    logic    reset      = 1'b1;
    logic    cfg_valid  = 1'b0;
    len_t    cfg_len    = '0;
    logic    cmd_valid  = 1'b0;
    cmd_t    cmd        = '0;
    logic    in_valid   = 1'b0;
    elem_t   in_data    = '0;
    logic    out_credit = 1'b0;
    logic    busy;
    logic    out_valid;
    result_t out_data;
    logic    out_last;

    //////////////////////////////////////////////////////////////////////
    // step table
    //////////////////////////////////////////////////////////////////////

    step_t steps [NUM_STEPS] = '{
        // short vectors, write both banks then read back
        '{8'h01, len_t'(8),    1'b0, POKE_NONE},
        '{8'h81, len_t'(0),    1'b0, POKE_NONE},
        // config write during the read must be ignored
        '{8'h02, len_t'(0),    1'b0, POKE_CFG},
        '{8'h82, len_t'(0),    1'b0, POKE_NONE},
        '{8'h04, len_t'(0),    1'b0, POKE_NONE},
        '{8'h08, len_t'(0),    1'b0, POKE_NONE},
        '{8'h10, len_t'(0),    1'b0, POKE_NONE},
        '{8'h20, len_t'(0),    1'b0, POKE_NONE},
        '{8'h40, len_t'(0),    1'b0, POKE_NONE},
        // sum and dot bits together, sum wins
        '{8'h44, len_t'(0),    1'b0, POKE_NONE},
        // no op bit at all
        '{8'h00, len_t'(0),    1'b0, POKE_NONE},
        '{8'h02, len_t'(0),    1'b0, POKE_CMD},
        // full depth
        '{8'h01, len_t'(1024), 1'b0, POKE_NONE},
        '{8'h81, len_t'(0),    1'b0, POKE_NONE},
        '{8'h04, len_t'(40),   1'b1, POKE_NONE},
        '{8'h02, len_t'(1024), 1'b0, POKE_NONE},
        '{8'h82, len_t'(0),    1'b1, POKE_NONE},
        '{8'h40, len_t'(0),    1'b0, POKE_NONE},
        '{8'h10, len_t'(0),    1'b0, POKE_NONE}
    };

    // source vectors, bank A always gets vec_a and bank B vec_b
    int      vec_a [MAX_LEN];
    int      vec_b [MAX_LEN];
    result_t exp_data [$];
    logic    exp_last [$];

    int   cur_len      = DEF_LEN;
    int   words_queued = 0;
    int   words_seen   = 0;
    int   credits_back = 0;
    int   hold_cnt     = 0;
    int   cycle_count  = 0;
    int   cycle_limit  = 1_000_000;
    logic withhold     = 1'b0;

    vecu_top #(
        .CREDITS     (CREDITS),
        .DEFAULT_LEN (len_t'(DEF_LEN))
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .cfg_valid  (cfg_valid),
        .cfg_len    (cfg_len),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .out_credit (out_credit),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input result_t actual, input result_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // index of the lowest op bit, -1 when none is set
    function automatic int lowest_op(input cmd_t c);
        int b;
        int op;
        op = -1;
        for (b = 6; b >= 0; b--) begin
            if (c[b]) op = b;
        end
        return op;
    endfunction

    // reference model of one command over the current length
    task automatic queue_expected(input cmd_t c);
        int op;
        int i;
        int a;
        int b;
        int acc;
        int word;
        op   = lowest_op(c);
        acc  = 0;
        word = 0;
        for (i = 0; i < cur_len; i++) begin
            a = vec_a[i];
            b = vec_b[i];
            case (op)
                1: word = c[CMD_BANK] ? b : a;
                2: word = a + b;
                // floor of the half-sum
                3: word = (a + b) / 2;
                4: acc = acc + (a - b) * (a - b);
                5: acc = acc + ((a > b) ? (a - b) : (b - a));
                6: acc = acc + a * b;
                default: word = 0;
            endcase
            if (op >= 1 && op <= 3) begin
                exp_data.push_back(result_t'(word));
                exp_last.push_back(i == cur_len - 1);
                words_queued++;
            end
        end
        // reductions give one word, always last
        if (op >= 4) begin
            exp_data.push_back(result_t'(acc));
            exp_last.push_back(1'b1);
            words_queued++;
        end
    endtask

    // write data with random idle cycles in between
    task automatic drive_vector(input logic to_b);
        int i;
        i = 0;
        while (i < cur_len) begin
            if ($urandom_range(3, 0) == 0) begin
                in_valid <= 1'b0;
            end else begin
                in_valid <= 1'b1;
                in_data  <= elem_t'(to_b ? vec_b[i] : vec_a[i]);
                i++;
            end
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    // host traffic that the busy DUT has to drop
    task automatic poke_while_busy(input logic [1:0] kind);
        if (kind == POKE_CFG) begin
            cfg_valid <= 1'b1;
            cfg_len   <= len_t'(3);
            @(posedge clk);
            cfg_valid <= 1'b0;
        end else if (kind == POKE_CMD) begin
            cmd_valid <= 1'b1;
            cmd       <= 8'h40;
            @(posedge clk);
            cmd_valid <= 1'b0;
        end
    endtask

    task automatic run_step(input step_t st);
        int op;
        op = lowest_op(st.cmd);
        if (st.len != '0) begin
            @(posedge clk);
            cfg_valid <= 1'b1;
            cfg_len   <= st.len;
            @(posedge clk);
            cfg_valid <= 1'b0;
            cur_len = int'(st.len);
        end
        withhold = st.withhold;
        queue_expected(st.cmd);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= st.cmd;
        @(posedge clk);
        cmd_valid <= 1'b0;
        @(negedge clk);
        if (op < 0) begin
            // dropped byte, unit stays idle
            repeat (8) begin
                check_value(result_t'(busy), 0, "busy after a byte with no op bit");
                @(negedge clk);
            end
        end else begin
            check_value(result_t'(busy), 1, "busy after an accepted command");
            @(posedge clk);
            if (op == 0) begin
                drive_vector(st.cmd[CMD_BANK]);
            end else begin
                poke_while_busy(st.poke);
            end
            do begin
                @(negedge clk);
            end while (busy);
            // a few quiet cycles to catch stray words
            repeat (4) @(negedge clk);
            check_value(result_t'(exp_data.size()), 0, "words missing at end of command");
        end
    endtask

    // slow credit return dominates the withheld steps
    function automatic int cycle_budget();
        int total;
        int len;
        int s;
        total = 200;
        len   = DEF_LEN;
        for (s = 0; s < NUM_STEPS; s++) begin
            if (steps[s].len != '0) len = int'(steps[s].len);
            total = total + 64 + len * (steps[s].withhold ? HOLD_CYCLES + 2 : 4);
        end
        return total;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // monitor, receiver and watchdog
    //////////////////////////////////////////////////////////////////////

    // outputs are registered, stable at the falling edge
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            words_seen++;
            check_value(result_t'(words_seen <= CREDITS + credits_back), 1,
                        "words within returned credits");
            if (exp_data.size() == 0) begin
                check_value(result_t'(out_valid), 0, "output word while none expected");
            end else begin
                check_value(out_data, exp_data.pop_front(), "output data");
                check_value(result_t'(out_last), result_t'(exp_last.pop_front()),
                            "out_last flag");
            end
        end
    end

    // one credit per word, late when held back
    always @(posedge clk) begin
        if (reset) begin
            out_credit <= 1'b0;
            hold_cnt = 0;
        end else if (words_seen > credits_back && (!withhold || hold_cnt >= HOLD_CYCLES)) begin
            out_credit <= 1'b1;
            credits_back++;
            hold_cnt = 0;
        end else begin
            out_credit <= 1'b0;
            if (words_seen > credits_back) hold_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Test failures found");
            $fatal(1, "timeout, the run did not finish within %0d cycles", cycle_limit);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int i;
        int s;
        void'($urandom(32'h23e1_f732));
        for (i = 0; i < MAX_LEN; i++) begin
            vec_a[i] = int'($urandom_range(255, 0));
            vec_b[i] = int'($urandom_range(255, 0));
        end
        cycle_limit = cycle_budget();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (s = 0; s < NUM_STEPS; s++) begin
            run_step(steps[s]);
        end
        repeat (8) @(negedge clk);
        if (exp_data.size() == 0 && words_seen == words_queued) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- vecu.f
vecu_pkg.sv
vecu_regs.sv
vecu_ctrl.sv
vecu_bank.sv
vecu_core.sv
vecu_top.sv
vecu_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := vecu_tb
FILELIST   := vecu.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := All tests passed!

SOURCES    := $(shell cat $(FILELIST))
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass message shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
